// File: hw/snd_params.svh
// Sound board widths, decoder region codes and ADPCM block geometry
`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// Sound CPU address bus
`define SND_AW 21

// External ROM, bit 17 splits program from ADPCM samples
`define SND_ROM_AW 18

// Program half of the external ROM
`define SND_PROG_AW 16

// 8 KB work RAM
`define SND_RAM_AW 13

// Upper address codes seen on A[20:16], I/O page uses A[19:16] with A20 set
`define SND_HI_ROM 5'h00
`define SND_HI_RAM 5'h1f
`define SND_HI_IO 4'h3

// Bytes in one ADPCM block and the shift from start byte to block address
`define SND_ADPCM_LEN 16
`define SND_BLOCK_SHIFT 4

`endif

// File: hw/snd_pkg.sv
// Shared types for the sound board, decoded regions and ROM grant owner
package snd_pkg;

    // Regions the sound CPU address can fall into
    typedef enum logic [2:0] {
        // Open bus, reads FF
        region_none,
        // Program ROM, lower 64 KB
        region_rom,
        // Work RAM at 1F0000
        region_ram,
        // ADPCM start and status register
        region_adpcm,
        // Sound latch from the main CPU
        region_latch
    } snd_region_t;

    // Current owner of the external ROM
    typedef enum logic [1:0] {
        // Nobody holds the ROM
        grant_idle,
        // Decoder program fetch
        grant_prog,
        // ADPCM sample fetcher
        grant_adpcm
    } rom_grant_t;

endpackage

// File: hw/rom_port_if.sv
// ROM request port between one requester and the ROM arbiter
`timescale 1ns/1ps
`include "snd_params.svh"

interface rom_port_if;

    // Request level, held with addr until ok is seen
    logic                  cs;
    logic [`SND_ROM_AW-1:0] addr;

    // Read data, valid while ok and cs are both high
    logic [7:0]            data;
    logic                  ok;

    // Side that asks for ROM bytes
    modport requester (
        output cs,
        output addr,
        input  data,
        input  ok
    );

    // Side that owns the physical ROM
    modport arbiter (
        input  cs,
        input  addr,
        output data,
        output ok
    );

endinterface

// File: hw/snd_ram.sv
// Sound CPU work RAM, 8 KB with a registered read port
`timescale 1ns/1ps
`include "snd_params.svh"

module snd_ram (
    input  logic                   clk,
    input  logic [`SND_RAM_AW-1:0] addr,
    input  logic [7:0]             din,
    input  logic                   we,
    output logic [7:0]             q
);
    // Storage array
    logic [7:0] mem [0:(1 << `SND_RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        // Read returns the old contents on a write cycle
        q <= mem[addr];
    end

endmodule

// File: hw/snd_decoder.sv
// Sound CPU address decoder with select latching, read mux, wait and NMI latch
`timescale 1ns/1ps
`include "snd_params.svh"

module snd_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`SND_AW-1:0]     cpu_addr,
    input  logic [7:0]             cpu_dout,
    input  logic                   cpu_wrn,
    input  logic                   cpu_sx,
    input  logic                   cpu_ce,
    input  logic                   snreq,
    input  logic [7:0]             latch,
    input  logic [7:0]             ram_q,
    input  logic [7:0]             adpcm_status,
    output logic [7:0]             cpu_din,
    output logic                   cpu_waitn,
    output logic                   nmi_n,
    output logic [`SND_RAM_AW-1:0] ram_addr,
    output logic                   ram_we,
    output logic                   adpcm_we,
    rom_port_if.requester          prog
);
    snd_pkg::snd_region_t addr_region;
    snd_pkg::snd_region_t region;
    logic                 rom_sel;
    logic                 ram_sel;
    logic                 adpcm_sel;
    logic                 latch_sel;

    function automatic snd_pkg::snd_region_t decode(input logic [`SND_AW-1:0] a);
        snd_pkg::snd_region_t r;
        r = snd_pkg::region_none;
        if (a[`SND_AW-1 -: 5] == `SND_HI_ROM) begin
            r = snd_pkg::region_rom;
        end else if (a[`SND_AW-1 -: 5] == `SND_HI_RAM) begin
            r = snd_pkg::region_ram;
        end else if (a[`SND_AW-1] && a[`SND_AW-2 -: 4] == `SND_HI_IO) begin
            // A15 splits the I/O page
            if (a[`SND_PROG_AW-1]) begin
                r = snd_pkg::region_latch;
            end else begin
                r = snd_pkg::region_adpcm;
            end
        end
        return r;
    endfunction

    always_comb begin
        addr_region = decode(cpu_addr);
    end

    // Region is taken at sx and dropped at ce, latch select tracks the address
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            region    <= snd_pkg::region_none;
            latch_sel <= 1'b0;
        end else begin
            latch_sel <= addr_region == snd_pkg::region_latch;
            if (cpu_sx) begin
                region <= addr_region;
            end else if (cpu_ce) begin
                region <= snd_pkg::region_none;
            end
        end
    end

    assign rom_sel   = region == snd_pkg::region_rom;
    assign ram_sel   = region == snd_pkg::region_ram;
    assign adpcm_sel = region == snd_pkg::region_adpcm;

    // Program fetch lives in the lower half of the shared ROM
    assign prog.cs   = rom_sel;
    assign prog.addr = {{(`SND_ROM_AW-`SND_PROG_AW){1'b0}}, cpu_addr[`SND_PROG_AW-1:0]};

    assign ram_addr = cpu_addr[`SND_RAM_AW-1:0];
    // Writes land on the ce cycle
    assign ram_we   = ram_sel && !cpu_wrn && cpu_ce;
    assign adpcm_we = adpcm_sel && !cpu_wrn && cpu_ce;

    // Read data mux, during writes the bus carries the CPU's own byte
    always_ff @(posedge clk) begin
        if (!cpu_wrn) begin
            cpu_din <= cpu_dout;
        end else if (ram_sel) begin
            cpu_din <= ram_q;
        end else if (adpcm_sel) begin
            cpu_din <= adpcm_status;
        end else if (latch_sel) begin
            cpu_din <= latch;
        end else if (rom_sel) begin
            cpu_din <= prog.data;
        end else begin
            cpu_din <= 8'hff;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_waitn <= 1'b1;
            nmi_n     <= 1'b1;
        end else begin
            // Stall the CPU until the ROM byte arrives
            cpu_waitn <= !(rom_sel && !prog.ok);
            // A new latch write beats the acknowledge
            if (snreq) begin
                nmi_n <= 1'b0;
            end else if (latch_sel && cpu_ce && cpu_wrn) begin
                nmi_n <= 1'b1;
            end
        end
    end

    a_one_select: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_sel, ram_sel, adpcm_sel, latch_sel}));

    a_ce_not_waiting: assert property (@(posedge clk) disable iff (rst)
        cpu_ce |-> cpu_waitn);

endmodule

// File: hw/adpcm_fetch.sv
// ADPCM block fetcher with busy status and byte output paced by cen_pcm
`timescale 1ns/1ps
`include "snd_params.svh"

module adpcm_fetch (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_we,
    input  logic [7:0]        start_byte,
    input  logic              cen_pcm,
    output logic              busy,
    output logic [7:0]        pcm_data,
    output logic              pcm_sample,
    rom_port_if.requester     pcm
);
    localparam int CNT_W = $clog2(`SND_ADPCM_LEN + 1);

    logic [CNT_W-1:0]       cnt;
    logic [`SND_ROM_AW-1:0] addr_q;
    logic [`SND_ROM_AW-1:0] start_addr;
    logic [7:0]             byte_buf;
    logic                   full;
    logic                   req;

    // Block start inside the ADPCM half, start byte times block length
    assign start_addr = {1'b1, {(`SND_ROM_AW-1-8-`SND_BLOCK_SHIFT){1'b0}},
                         start_byte, {`SND_BLOCK_SHIFT{1'b0}}};

    assign pcm.cs   = req;
    assign pcm.addr = addr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            full       <= 1'b0;
            req        <= 1'b0;
            cnt        <= '0;
            pcm_sample <= 1'b0;
        end else begin
            pcm_sample <= 1'b0;
            if (start_we) begin
                // Also restarts a running block, any pending fetch is dropped
                busy <= 1'b1;
                full <= 1'b0;
                req  <= 1'b0;
                cnt  <= '0;
            end else if (busy) begin
                if (req && pcm.ok) begin
                    req  <= 1'b0;
                    full <= 1'b1;
                end else if (!req && !full && cnt != CNT_W'(`SND_ADPCM_LEN)) begin
                    req <= 1'b1;
                end
                // Byte handed out on the sample enable, skipped if not ready
                if (full && cen_pcm) begin
                    full       <= 1'b0;
                    pcm_sample <= 1'b1;
                    cnt        <= cnt + 1'b1;
                end
                // Last sample already out
                if (cnt == CNT_W'(`SND_ADPCM_LEN)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Address and byte payload
    always_ff @(posedge clk) begin
        if (start_we) begin
            addr_q <= start_addr;
        end else if (busy && req && pcm.ok) begin
            byte_buf <= pcm.data;
            addr_q   <= addr_q + 1'b1;
        end
        if (!start_we && busy && full && cen_pcm) begin
            pcm_data <= byte_buf;
        end
    end

    a_sample_while_busy: assert property (@(posedge clk) disable iff (rst)
        pcm_sample |-> busy);

endmodule

// File: hw/rom_arbiter.sv
// Fixed-priority arbiter sharing the external ROM between program and ADPCM
`timescale 1ns/1ps
`include "snd_params.svh"

module rom_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    output logic                   rom_cs,
    output logic [`SND_ROM_AW-1:0] rom_addr,
    rom_port_if.arbiter            prog,
    rom_port_if.arbiter            pcm
);
    snd_pkg::rom_grant_t grant;

    // Grant in idle only with program fetch first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= snd_pkg::grant_idle;
        end else begin
            case (grant)
                snd_pkg::grant_idle: begin
                    if (prog.cs) begin
                        grant <= snd_pkg::grant_prog;
                    end else if (pcm.cs) begin
                        grant <= snd_pkg::grant_adpcm;
                    end
                end
                // Owner keeps the ROM until its cs falls
                snd_pkg::grant_prog: begin
                    if (!prog.cs) begin
                        grant <= snd_pkg::grant_idle;
                    end
                end
                snd_pkg::grant_adpcm: begin
                    if (!pcm.cs) begin
                        grant <= snd_pkg::grant_idle;
                    end
                end
                default: grant <= snd_pkg::grant_idle;
            endcase
        end
    end

    // ROM pins follow the owner
    always_comb begin
        rom_cs   = 1'b0;
        rom_addr = prog.addr;
        if (grant == snd_pkg::grant_prog) begin
            rom_cs = prog.cs;
        end else if (grant == snd_pkg::grant_adpcm) begin
            rom_cs   = pcm.cs;
            rom_addr = pcm.addr;
        end
    end

    // Only the owner sees the answer
    assign prog.ok   = rom_ok && grant == snd_pkg::grant_prog;
    assign pcm.ok    = rom_ok && grant == snd_pkg::grant_adpcm;
    assign prog.data = grant == snd_pkg::grant_prog ? rom_data : 8'h00;
    assign pcm.data  = grant == snd_pkg::grant_adpcm ? rom_data : 8'h00;

    // A pending request keeps its owner and address until the ROM answers
    a_request_held: assert property (@(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok) |=> (!rom_cs || rom_addr == $past(rom_addr)));

endmodule

// File: hw/snd_board.sv
// Sound board top level, decoder, work RAM, ADPCM fetcher and ROM arbiter
`timescale 1ns/1ps
`include "snd_params.svh"

module snd_board (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`SND_AW-1:0]     cpu_addr,
    input  logic [7:0]             cpu_dout,
    input  logic                   cpu_wrn,
    input  logic                   cpu_sx,
    input  logic                   cpu_ce,
    input  logic                   snreq,
    input  logic [7:0]             latch,
    input  logic                   cen_pcm,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    output logic [7:0]             cpu_din,
    output logic                   cpu_waitn,
    output logic                   nmi_n,
    output logic                   rom_cs,
    output logic [`SND_ROM_AW-1:0] rom_addr,
    output logic [7:0]             pcm_data,
    output logic                   pcm_sample,
    output logic [7:0]             status
);
    logic [`SND_RAM_AW-1:0] ram_addr;
    logic                   ram_we;
    logic [7:0]             ram_q;
    logic                   adpcm_we;
    logic                   busy;
    logic [7:0]             adpcm_status;

    // One port per ROM requester
    rom_port_if prog_port ();
    rom_port_if pcm_port ();

    // ADPCM register reads busy in bit 0
    assign adpcm_status = {7'd0, busy};
    // Main CPU status, pending NMI on top and ADPCM busy at the bottom
    assign status       = {nmi_n, 6'd0, busy};

    snd_decoder i_snd_decoder (
        .clk          (clk),
        .rst          (rst),
        .cpu_addr     (cpu_addr),
        .cpu_dout     (cpu_dout),
        .cpu_wrn      (cpu_wrn),
        .cpu_sx       (cpu_sx),
        .cpu_ce       (cpu_ce),
        .snreq        (snreq),
        .latch        (latch),
        .ram_q        (ram_q),
        .adpcm_status (adpcm_status),
        .cpu_din      (cpu_din),
        .cpu_waitn    (cpu_waitn),
        .nmi_n        (nmi_n),
        .ram_addr     (ram_addr),
        .ram_we       (ram_we),
        .adpcm_we     (adpcm_we),
        .prog         (prog_port.requester)
    );

    snd_ram i_snd_ram (
        .clk  (clk),
        .addr (ram_addr),
        .din  (cpu_dout),
        .we   (ram_we),
        .q    (ram_q)
    );

    adpcm_fetch i_adpcm_fetch (
        .clk        (clk),
        .rst        (rst),
        .start_we   (adpcm_we),
        .start_byte (cpu_dout),
        .cen_pcm    (cen_pcm),
        .busy       (busy),
        .pcm_data   (pcm_data),
        .pcm_sample (pcm_sample),
        .pcm        (pcm_port.requester)
    );

    rom_arbiter i_rom_arbiter (
        .clk      (clk),
        .rst      (rst),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .prog     (prog_port.arbiter),
        .pcm      (pcm_port.arbiter)
    );

endmodule

// File: bench/snd_board_tb.sv
// Sound board testbench with CPU bus tasks, ROM model, stimulus table and checks
`timescale 1ns/1ps
`include "snd_params.svh"

module snd_board_tb;

    // Kinds of table steps
    typedef enum logic [2:0] {
        do_read,
        do_write,
        do_snreq,
        do_start,
        do_status,
        do_drain
    } step_kind_t;

    typedef struct packed {
        step_kind_t         kind;
        logic [`SND_AW-1:0] addr;
        logic [7:0]         data;
        logic [7:0]         exp;
    } step_t;

    logic                   clk;
    logic                   rst;
    logic [`SND_AW-1:0]     cpu_addr;
    logic [7:0]             cpu_dout;
    logic                   cpu_wrn;
    logic                   cpu_sx;
    logic                   cpu_ce;
    logic                   snreq;
    logic [7:0]             latch;
    logic                   cen_pcm;
    logic [7:0]             rom_data;
    logic                   rom_ok;
    logic [7:0]             cpu_din;
    logic                   cpu_waitn;
    logic                   nmi_n;
    logic                   rom_cs;
    logic [`SND_ROM_AW-1:0] rom_addr;
    logic [7:0]             pcm_data;
    logic                   pcm_sample;
    logic [7:0]             status;

    step_t                  steps[$];
    logic [7:0]             pcm_exp[$];
    logic [7:0]             samples_seen;
    logic [7:0]             samples_wanted;
    logic                   table_ready;
    int                     cur_step;
    logic [31:0]            lfsr;
    logic                   rom_live;
    logic [`SND_ROM_AW-1:0] rom_last;
    logic [2:0]             rom_wait;
    logic [2:0]             cen_cnt;

    snd_board i_snd_board (
        .clk        (clk),
        .rst        (rst),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .cpu_wrn    (cpu_wrn),
        .cpu_sx     (cpu_sx),
        .cpu_ce     (cpu_ce),
        .snreq      (snreq),
        .latch      (latch),
        .cen_pcm    (cen_pcm),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .cpu_din    (cpu_din),
        .cpu_waitn  (cpu_waitn),
        .nmi_n      (nmi_n),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .pcm_data   (pcm_data),
        .pcm_sample (pcm_sample),
        .status     (status)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    // Reference ROM contents
    // Only the low byte of a[17:8] matters in the 8-bit sum
    function automatic logic [7:0] rom_byte(input logic [`SND_ROM_AW-1:0] a);
        logic [9:0] hi;
        hi = a[17:8];
        return (a[7:0] ^ 8'h5a) + hi[7:0];
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1 giving one bit per call
    function logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    // ROM answer delay of 1 to 4 cycles
    function logic [2:0] draw_delay();
        logic [2:0] d;
        d = 3'd1;
        if (lfsr_step()) d = d + 3'd1;
        if (lfsr_step()) d = d + 3'd2;
        return d;
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED: %s = %h, expected %h (step %0d)", name, got, exp, cur_step);
            abort_run();
        end
    endtask

    // External ROM model holds ok while cs and addr stay put
    always @(negedge clk) begin
        if (rst || !rom_cs) begin
            rom_ok   = 1'b0;
            rom_live = 1'b0;
        end else if (!rom_live || rom_addr != rom_last) begin
            rom_live = 1'b1;
            rom_last = rom_addr;
            rom_ok   = 1'b0;
            rom_wait = draw_delay();
        end else if (rom_wait > 3'd1) begin
            rom_wait = rom_wait - 3'd1;
        end else begin
            rom_ok   = 1'b1;
            rom_data = rom_byte(rom_last);
        end
    end

    // Sample enable every 8 cycles
    always @(negedge clk) begin
        if (rst) begin
            cen_cnt = 3'd0;
        end else begin
            cen_cnt = cen_cnt + 3'd1;
        end
        cen_pcm = cen_cnt == 3'd7;
    end

    // ADPCM bytes must match the expected queue in order
    always @(negedge clk) begin
        if (!rst && pcm_sample) begin
            if (pcm_exp.size() == 0) begin
                $display("ADPCM sample came out with no byte expected (step %0d)", cur_step);
                abort_run();
            end else begin
                check_value("pcm_data", pcm_data, pcm_exp.pop_front());
                samples_seen = samples_seen + 8'd1;
            end
        end
    end

    // One CPU access pulses sx and then ce once waitn allows it
    task automatic bus_cycle(input logic [`SND_AW-1:0] a, input logic wr,
                             input logic [7:0] d, output logic [7:0] q);
        @(negedge clk);
        cpu_addr = a;
        cpu_wrn  = !wr;
        cpu_dout = d;
        cpu_sx   = 1'b1;
        @(negedge clk);
        cpu_sx = 1'b0;
        repeat (2) @(negedge clk);
        while (!cpu_waitn) @(negedge clk);
        cpu_ce = 1'b1;
        @(negedge clk);
        cpu_ce  = 1'b0;
        q       = cpu_din;
        cpu_wrn = 1'b1;
    endtask

    task automatic run_step(input step_t s);
        logic [7:0]             q;
        logic [`SND_ROM_AW-1:0] blk;
        int                     i;
        case (s.kind)
            do_read: begin
                bus_cycle(s.addr, 1'b0, 8'h00, q);
                check_value("cpu_din", q, s.exp);
            end
            do_write: begin
                bus_cycle(s.addr, 1'b1, s.data, q);
            end
            do_snreq: begin
                @(negedge clk);
                latch = s.data;
                snreq = 1'b1;
                @(negedge clk);
                snreq = 1'b0;
            end
            do_start: begin
                // Block begins at start byte times 16 in the ADPCM half
                blk = 18'h20000 + ({10'd0, s.data} << `SND_BLOCK_SHIFT);
                for (i = 0; i < `SND_ADPCM_LEN; i++) begin
                    pcm_exp.push_back(rom_byte(blk + 18'(i)));
                end
                samples_wanted = samples_wanted + 8'(`SND_ADPCM_LEN);
                bus_cycle(s.addr, 1'b1, s.data, q);
            end
            do_status: begin
                @(negedge clk);
                check_value("status", status, s.exp);
            end
            do_drain: begin
                @(negedge clk);
                while (status[0]) @(negedge clk);
                check_value("pcm_sample count", samples_seen, samples_wanted);
            end
            default: begin
            end
        endcase
    endtask

    task automatic add_step(input step_kind_t kind, input logic [`SND_AW-1:0] addr,
                            input logic [7:0] data, input logic [7:0] exp);
        step_t s;
        s.kind = kind;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endtask

    // Program fetch sees the lower ROM half only
    task automatic add_rom_read(input logic [`SND_AW-1:0] addr);
        add_step(do_read, addr, 8'h00, rom_byte({2'b00, addr[15:0]}));
    endtask

    task automatic build_table();
        // Work RAM and open bus
        add_step(do_write, 21'h1f0000, 8'h3c, 8'h00);
        add_step(do_write, 21'h1f0123, 8'ha5, 8'h00);
        add_step(do_write, 21'h1f1fff, 8'h7e, 8'h00);
        add_step(do_write, 21'h1f0800, 8'h11, 8'h00);
        add_step(do_read, 21'h1f0123, 8'h00, 8'ha5);
        add_step(do_read, 21'h1f0000, 8'h00, 8'h3c);
        add_step(do_read, 21'h1f1fff, 8'h00, 8'h7e);
        add_step(do_read, 21'h1f0800, 8'h00, 8'h11);
        add_step(do_read, 21'h050000, 8'h00, 8'hff);
        add_step(do_read, 21'h100000, 8'h00, 8'hff);
        add_step(do_read, 21'h1e4000, 8'h00, 8'hff);
        // Program ROM with random ok delay
        add_rom_read(21'h000000);
        add_rom_read(21'h001234);
        add_rom_read(21'h00abcd);
        add_rom_read(21'h00ffff);
        add_rom_read(21'h007f80);
        // Sound latch and NMI
        add_step(do_snreq, 21'h000000, 8'h96, 8'h00);
        add_step(do_status, 21'h000000, 8'h00, 8'h00);
        add_step(do_read, 21'h138000, 8'h00, 8'h96);
        add_step(do_status, 21'h000000, 8'h00, 8'h80);
        // One ADPCM block on its own
        add_step(do_start, 21'h130000, 8'h12, 8'h00);
        add_step(do_status, 21'h000000, 8'h00, 8'h81);
        add_step(do_read, 21'h130000, 8'h00, 8'h01);
        add_step(do_drain, 21'h000000, 8'h00, 8'h00);
        add_step(do_read, 21'h130000, 8'h00, 8'h00);
        add_step(do_status, 21'h000000, 8'h00, 8'h80);
        // ROM shared with a running block
        add_step(do_start, 21'h130000, 8'hc5, 8'h00);
        add_rom_read(21'h000321);
        add_rom_read(21'h00fedc);
        add_rom_read(21'h004000);
        add_rom_read(21'h008421);
        add_step(do_drain, 21'h000000, 8'h00, 8'h00);
        add_step(do_status, 21'h000000, 8'h00, 8'h80);
    endtask

    // Run length follows the table size
    initial begin
        wait (table_ready);
        repeat (steps.size() * 40 + 200) @(posedge clk);
        $display("Watchdog expired before the stimulus table finished (step %0d)", cur_step);
        abort_run();
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        cpu_addr       = '0;
        cpu_dout       = 8'h00;
        cpu_wrn        = 1'b1;
        cpu_sx         = 1'b0;
        cpu_ce         = 1'b0;
        snreq          = 1'b0;
        latch          = 8'h00;
        cen_pcm        = 1'b0;
        rom_data       = 8'h00;
        rom_ok         = 1'b0;
        lfsr           = 32'he04c_62e2;
        rom_live       = 1'b0;
        rom_last       = '0;
        rom_wait       = 3'd0;
        cen_cnt        = 3'd0;
        samples_seen   = 8'd0;
        samples_wanted = 8'd0;
        cur_step       = -1;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        // Idle outputs after reset
        check_value("cpu_waitn", {7'd0, cpu_waitn}, 8'h01);
        check_value("nmi_n", {7'd0, nmi_n}, 8'h01);
        check_value("rom_cs", {7'd0, rom_cs}, 8'h00);
        check_value("pcm_sample", {7'd0, pcm_sample}, 8'h00);
        check_value("status", status, 8'h80);
        foreach (steps[n]) begin
            cur_step = n;
            run_step(steps[n]);
        end
        repeat (4) @(negedge clk);
        if (pcm_exp.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("%0d ADPCM bytes never came out", pcm_exp.size());
            abort_run();
        end
    end

endmodule

// File: snd_board.f
+incdir+hw
hw/snd_pkg.sv
hw/rom_port_if.sv
hw/snd_ram.sv
hw/snd_decoder.sv
hw/adpcm_fetch.sv
hw/rom_arbiter.sv
hw/snd_board.sv
bench/snd_board_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the sound board testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f snd_board.f \
    --top-module snd_board_tb \
    -o snd_board_sim

out=$(./obj_dir/snd_board_sim)
echo "$out"
echo "$out" | grep -q "Simulation passed"
